// ==== tapc.f ====
+incdir+design
design/tapc_pkg.sv
design/tapc_ctrl_if.sv
design/tap_fsm.sv
design/tap_ir.sv
design/dr_capture_reg.sv
design/tdo_out.sv
design/tapc_top.sv
tb/tapc_chk.sv
tb/tapc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the TAP controller testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f tapc.f --top-module tapc_tb -Mdir obj_dir -o tapc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tapc_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Verification passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== tb/tapc_tb.sv ====
// Directed testbench for the JTAG TAP controller
// Drives the pins 2 ns after each rising tck edge and samples tdo on the rising edge

`include "tapc_defines.svh"

module tapc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 2000;   // Tests need about 450 cycles
    localparam int DMI_LEN    = 32;

    logic               trst_n, tck, tms, tdi, tdo, tdo_en;
    tapc_pkg::dr_word_t fuse_idcode;
    tapc_pkg::dmi_id_t  dmi_ch_id;
    logic               dmi_ch_sel, dmi_ch_capture, dmi_ch_shift, dmi_ch_update;
    logic               dmi_ch_tdi, dmi_ch_tdo;

    int unsigned cycle_count;
    int          error_count  = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [2:0]  strobe_trace [$];     // {capture, shift, update} per cycle

    tapc_top i_dut (.*);

    initial begin
        tck = 1'b0;
        forever #20 tck = ~tck;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge tck);
            cycle_count++;
        end
        $display("Timeout, run stopped after %0d tck cycles", cycle_count);
        $display("Verification failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic check_word(input string name, input tapc_pkg::dr_word_t exp,
                              input tapc_pkg::dr_word_t act);
        if (act !== exp) begin
            error_count++;
            $display("Mismatch at %0d ns: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            $display("Mismatch at %0d ns: %s expected %b, actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_dmi_id(input string name, input tapc_pkg::dmi_id_t exp,
                                input tapc_pkg::dmi_id_t act);
        if (act !== exp) begin
            error_count++;
            $display("Mismatch at %0d ns: %s expected %0d, actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            tests_passed++;
            $display("Test %s done, no mismatches", name);
        end else begin
            tests_failed++;
            $display("Test %s done, %0d mismatches", name, error_count - errs_before);
        end
    endtask

    // ----------------------------------------------------------------------
    // JTAG driving
    // ----------------------------------------------------------------------
    // Runs one tck cycle and reads the strobes mid-cycle and tdo at the closing edge
    task automatic tap_step(input logic tms_v, input logic tdi_v, input logic dmi_v,
                            output logic tdo_v);
        tms        = tms_v;
        tdi        = tdi_v;
        dmi_ch_tdo = dmi_v;
        @(negedge tck);
        strobe_trace.push_back({dmi_ch_capture, dmi_ch_shift, dmi_ch_update});
        check_bit("dmi_ch_tdi", tdi_v, dmi_ch_tdi);   // Straight pass-through
        @(posedge tck);
        tdo_v = tdo;
        #2;
    endtask

    task automatic tap_reset();
        logic bit_out;
        int   i;
        for (i = 0; i < 5; i++) begin
            tap_step(1'b1, 1'b0, 1'b0, bit_out);
        end
        tap_step(1'b0, 1'b0, 1'b0, bit_out);         // To Idle
    endtask

    // Goes from Idle to Update-IR and back and returns what came out on tdo
    task automatic shift_ir(input tapc_pkg::instr_t code, output tapc_pkg::instr_t captured);
        logic bit_out;
        int   i;
        tap_step(1'b1, 1'b0, 1'b0, bit_out);         // Select-DR
        tap_step(1'b1, 1'b0, 1'b0, bit_out);         // Select-IR
        tap_step(1'b0, 1'b0, 1'b0, bit_out);         // Capture-IR
        tap_step(1'b0, 1'b0, 1'b0, bit_out);         // Shift-IR
        for (i = 0; i < `TAPC_IR_WIDTH; i++) begin
            tap_step(i == `TAPC_IR_WIDTH - 1, code[i], 1'b0, bit_out);
            captured[i] = bit_out;
            check_bit("tdo_en", 1'b1, tdo_en);        // Pad driven for every IR bit
        end
        tap_step(1'b1, 1'b0, 1'b0, bit_out);         // Update-IR
        tap_step(1'b0, 1'b0, 1'b0, bit_out);         // Idle
    endtask

    // Takes n + 5 cycles in all with tms high on the last shift cycle
    task automatic shift_dr(input int n, input logic [63:0] data_in,
                            input logic [63:0] dmi_in, output logic [63:0] data_out);
        logic bit_out;
        int   i;
        data_out = '0;
        tap_step(1'b1, 1'b0, 1'b0, bit_out);         // Select-DR
        tap_step(1'b0, 1'b0, 1'b0, bit_out);         // Capture-DR
        tap_step(1'b0, 1'b0, 1'b0, bit_out);         // Shift-DR
        for (i = 0; i < n; i++) begin
            tap_step(i == n - 1, data_in[i], dmi_in[i], bit_out);
            data_out[i] = bit_out;
            check_bit("tdo_en", 1'b1, tdo_en);        // Pad driven for every DR bit
        end
        tap_step(1'b1, 1'b0, 1'b0, bit_out);         // Update-DR
        tap_step(1'b0, 1'b0, 1'b0, bit_out);         // Idle
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic reset_default();
        int          errs;
        logic [63:0] dout;
        errs = error_count;
        tap_reset();
        check_bit("tdo_en", 1'b0, tdo_en);
        shift_dr(32, {$urandom, $urandom}, 64'h0, dout);
        check_word("tdo IDCODE", fuse_idcode, dout[31:0]);
        report_test("reset_default", errs);
    endtask

    task automatic ir_capture();
        int               errs;
        tapc_pkg::instr_t cap;
        logic [31:0]      rnd;
        errs = error_count;
        rnd = $urandom;
        shift_ir(rnd[4:0], cap);
        check_word("tdo IR capture", 32'h1, {27'b0, cap});
        shift_ir(`TAPC_INSTR_BYPASS, cap);
        check_word("tdo IR capture", 32'h1, {27'b0, cap});
        shift_ir(`TAPC_INSTR_IDCODE, cap);
        check_word("tdo IR capture", 32'h1, {27'b0, cap});
        report_test("ir_capture", errs);
    endtask

    task automatic bypass_path();
        int               errs, k;
        tapc_pkg::instr_t cap;
        logic [31:0]      rnd;
        logic [63:0]      dout;
        errs = error_count;
        for (k = 0; k < 2; k++) begin
            shift_ir((k == 0) ? `TAPC_INSTR_BYPASS : 5'h09, cap);   // 5'h09 is undefined
            rnd = $urandom;
            shift_dr(17, {48'b0, rnd[15:0]}, 64'h0, dout);
            check_word("tdo BYPASS", {15'b0, rnd[15:0], 1'b0}, dout[31:0]);
        end
        report_test("bypass_path", errs);
    endtask

    task automatic bld_id_readback();
        int               errs;
        tapc_pkg::instr_t cap;
        logic [63:0]      din, dout;
        errs = error_count;
        shift_ir(`TAPC_INSTR_BLD_ID, cap);
        shift_dr(32, {$urandom, $urandom}, 64'h0, dout);
        check_word("tdo BLD_ID", `TAPC_BLD_ID_VALUE, dout[31:0]);
        din = {$urandom, $urandom};
        shift_dr(64, din, 64'h0, dout);               // Second half is din delayed 32 bits
        check_word("tdo BLD_ID", `TAPC_BLD_ID_VALUE, dout[31:0]);
        check_word("tdo BLD_ID loop", din[31:0], dout[63:32]);
        report_test("bld_id_readback", errs);
    endtask

    task automatic dmi_chain_control();
        int                errs, k, j;
        tapc_pkg::instr_t  cap;
        tapc_pkg::dmi_id_t exp_id;
        logic [63:0]       dmi_pat, dout;
        logic [2:0]        exp_strobe;
        errs = error_count;
        for (k = 0; k < 2; k++) begin
            exp_id = (k == 0) ? `TAPC_DMI_ID_DTMCS : `TAPC_DMI_ID_ACCESS;
            shift_ir((k == 0) ? `TAPC_INSTR_DTMCS : `TAPC_INSTR_DMI_ACCESS, cap);
            check_bit("dmi_ch_sel", 1'b1, dmi_ch_sel);
            check_dmi_id("dmi_ch_id", exp_id, dmi_ch_id);
            dmi_pat = {$urandom, $urandom};
            strobe_trace.delete();
            shift_dr(DMI_LEN, {$urandom, $urandom}, dmi_pat, dout);
            check_word("tdo DMI", dmi_pat[31:0], dout[31:0]);
            // Idle, Select, Capture, Shift x n, Exit1, Update
            for (j = 0; j < strobe_trace.size(); j++) begin
                exp_strobe = (j == 2) ? 3'b100 :
                             (j >= 3 && j < DMI_LEN + 3) ? 3'b010 :
                             (j == DMI_LEN + 4) ? 3'b001 : 3'b000;
                check_bit("dmi_ch_capture", exp_strobe[2], strobe_trace[j][2]);
                check_bit("dmi_ch_shift", exp_strobe[1], strobe_trace[j][1]);
                check_bit("dmi_ch_update", exp_strobe[0], strobe_trace[j][0]);
            end
        end
        report_test("dmi_chain_control", errs);
    endtask

    task automatic tms_logic_reset();
        int               errs;
        tapc_pkg::instr_t cap;
        logic [31:0]      rnd;
        logic [63:0]      dout;
        errs = error_count;
        shift_ir(`TAPC_INSTR_DMI_ACCESS, cap);
        check_bit("dmi_ch_sel", 1'b1, dmi_ch_sel);
        tap_reset();
        check_bit("dmi_ch_sel", 1'b0, dmi_ch_sel);
        check_dmi_id("dmi_ch_id", 2'd0, dmi_ch_id);
        rnd = $urandom;
        fuse_idcode = rnd | 32'h1;                    // Fresh value proves a new capture
        shift_dr(32, {$urandom, $urandom}, 64'h0, dout);
        check_word("tdo IDCODE", fuse_idcode, dout[31:0]);
        report_test("tms_logic_reset", errs);
    endtask

    // ----------------------------------------------------------------------
    // Sequence
    // ----------------------------------------------------------------------
    initial begin
        int unsigned seed;
        seed        = $urandom(32'h21605080);
        trst_n      = 1'b0;
        tms         = 1'b1;
        tdi         = 1'b0;
        dmi_ch_tdo  = 1'b0;
        fuse_idcode = 32'h5A3C_7E2B;
        repeat (8) @(posedge tck);
        #2 trst_n = 1'b1;
        reset_default();
        ir_capture();
        bypass_path();
        bld_id_readback();
        dmi_chain_control();
        tms_logic_reset();
        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== tb/tapc_chk.sv ====
// Protocol assertions on the TAP controller pins and state
// Bound into tapc_top to watch the JTAG inputs, TDO enable and DMI strobes

module tapc_chk (
    input logic                 tck,
    input logic                 trst_n,
    input logic                 tms,
    input logic                 tdi,
    input logic                 tdo_en,
    input tapc_pkg::tap_state_e state,
    input logic                 dmi_ch_capture,
    input logic                 dmi_ch_shift,
    input logic                 dmi_ch_update
);
    timeunit 1ns;
    timeprecision 100ps;

    // JTAG inputs must be driven once reset is gone
    a_inputs_known: assert property (@(posedge tck) disable iff (!trst_n)
        !$isunknown({tms, tdi})) else $error("tms or tdi is unknown");

    // Only the shift states enable tdo_en, which trails the state by half a cycle
    a_tdo_en_shift_only: assert property (@(posedge tck) disable iff (!trst_n)
        (state != tapc_pkg::TAP_DR_SHIFT && state != tapc_pkg::TAP_IR_SHIFT) |-> !tdo_en)
        else $error("tdo_en high outside Shift-DR and Shift-IR");

    a_update_single: assert property (@(posedge tck) disable iff (!trst_n)
        dmi_ch_update |=> !dmi_ch_update) else $error("dmi_ch_update high two cycles");

    a_strobes_exclusive: assert property (@(posedge tck) disable iff (!trst_n)
        $onehot0({dmi_ch_capture, dmi_ch_shift, dmi_ch_update}))
        else $error("DMI capture, shift and update strobes overlap");

endmodule

bind tapc_top tapc_chk i_chk (
    .tck, .trst_n, .tms, .tdi, .tdo_en, .state (ctrl.state),
    .dmi_ch_capture, .dmi_ch_shift, .dmi_ch_update
);

// ==== design/tapc_top.sv ====
// Top level of the JTAG TAP controller
// Plain JTAG, fuse and DMI chain ports, internal blocks share one control bundle

`include "tapc_defines.svh"

module tapc_top (
    input  logic                 trst_n,
    input  logic                 tck,
    input  logic                 tms,
    input  logic                 tdi,
    output logic                 tdo,
    output logic                 tdo_en,          // TDO pad driver enable
    input  tapc_pkg::dr_word_t   fuse_idcode,     // IDCODE from fuses
    output logic                 dmi_ch_sel,
    output tapc_pkg::dmi_id_t    dmi_ch_id,
    output logic                 dmi_ch_capture,
    output logic                 dmi_ch_shift,
    output logic                 dmi_ch_update,
    output logic                 dmi_ch_tdi,
    input  logic                 dmi_ch_tdo
);

    tapc_ctrl_if ctrl ();

    tapc_pkg::dr_sel_e            dr_sel;
    logic                         ir_lsb;
    logic [`TAPC_NUM_ID_REGS-1:0] id_bits;
    tapc_pkg::dr_word_t           id_capture [`TAPC_NUM_ID_REGS];

    // ----------------------------------------------------------------------
    // Control and instruction
    // ----------------------------------------------------------------------
    tap_fsm u_fsm (.tck, .trst_n, .tms, .ctrl);

    tap_ir u_ir (
        .tck, .trst_n, .tdi, .ctrl, .ir_lsb, .dr_sel, .dmi_ch_sel, .dmi_ch_id
    );

    // ----------------------------------------------------------------------
    // IDCODE and BLD_ID registers
    // ----------------------------------------------------------------------
    assign id_capture[0] = fuse_idcode;         // Index 0 is IDCODE
    assign id_capture[1] = `TAPC_BLD_ID_VALUE;  // Index 1 is BLD_ID

    for (genvar i = 0; i < `TAPC_NUM_ID_REGS; i++) begin : g_id_reg
        dr_capture_reg u_dr (
            .tck, .trst_n, .tdi, .ctrl,
            .select        (dr_sel == tapc_pkg::dr_sel_e'(i)),
            .capture_value (id_capture[i]),
            .tdo_bit       (id_bits[i])
        );
    end

    tdo_out u_tdo (
        .tck, .trst_n, .tdi, .ctrl, .dr_sel, .ir_lsb, .id_bits, .dmi_ch_tdo, .tdo, .tdo_en
    );

    // DMI chain sees the raw strobes, dmi_ch_sel qualifies them
    assign dmi_ch_capture = ctrl.dr_capture;
    assign dmi_ch_shift   = ctrl.dr_shift;
    assign dmi_ch_update  = ctrl.dr_update;
    assign dmi_ch_tdi     = tdi;

endmodule

// ==== design/tdo_out.sv ====
// TDO stage with BYPASS bit, data register mux and falling-edge output
// tdo and tdo_en change on the falling edge, host samples on rising

`include "tapc_defines.svh"

module tdo_out (
    input  logic                          tck,
    input  logic                          trst_n,
    input  logic                          tdi,
    tapc_ctrl_if.tdo                      ctrl,
    input  tapc_pkg::dr_sel_e             dr_sel,
    input  logic                          ir_lsb,
    input  logic [`TAPC_NUM_ID_REGS-1:0]  id_bits,     // One bit per looped register
    input  logic                          dmi_ch_tdo,
    output logic                          tdo,
    output logic                          tdo_en
);

    logic bypass_q;     // BYPASS data register
    logic dr_bit;       // Selected data register output
    logic tdo_next;
    logic tdo_en_next;

    // ----------------------------------------------------------------------
    // BYPASS, captures 0 and passes tdi with one bit of delay
    // ----------------------------------------------------------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            bypass_q <= 1'b0;
        end else if (ctrl.tlr) begin
            bypass_q <= 1'b0;
        end else if (dr_sel == tapc_pkg::SEL_BYPASS) begin
            if (ctrl.dr_capture) begin
                bypass_q <= 1'b0;
            end else if (ctrl.dr_shift) begin
                bypass_q <= tdi;
            end
        end
    end

    // Data register mux, enum values double as id_bits index
    always_comb begin
        case (dr_sel)
            tapc_pkg::SEL_IDCODE,
            tapc_pkg::SEL_BLD_ID: dr_bit = id_bits[dr_sel[0]];
            tapc_pkg::SEL_DMI:    dr_bit = dmi_ch_tdo;
            default:              dr_bit = bypass_q;
        endcase
    end

    // DR shift wins over IR shift, they never overlap anyway
    assign tdo_en_next = ctrl.dr_shift | ctrl.ir_shift;
    assign tdo_next    = ctrl.dr_shift ? dr_bit : (ctrl.ir_shift & ir_lsb);

    // ----------------------------------------------------------------------
    // Output registers
    // ----------------------------------------------------------------------
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            tdo    <= 1'b0;
            tdo_en <= 1'b0;
        end else if (ctrl.tlr) begin
            tdo    <= 1'b0;
            tdo_en <= 1'b0;
        end else begin
            tdo    <= tdo_next;
            tdo_en <= tdo_en_next;
        end
    end

endmodule

// ==== design/dr_capture_reg.sv ====
// One 32-bit data register with parallel capture and serial shift
// Used for IDCODE and BLD_ID, only acts while selected

module dr_capture_reg (
    input  logic                 tck,
    input  logic                 trst_n,
    input  logic                 tdi,
    tapc_ctrl_if.dr              ctrl,
    input  logic                 select,         // Instruction picks this register
    input  tapc_pkg::dr_word_t   capture_value,  // Loaded in Capture-DR
    output logic                 tdo_bit
);

    tapc_pkg::dr_word_t shift_q;

    // ----------------------------------------------------------------------
    // Capture and shift
    // ----------------------------------------------------------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            shift_q <= '0;
        end else if (ctrl.tlr) begin
            shift_q <= '0;
        end else if (select && ctrl.dr_capture) begin
            shift_q <= capture_value;
        end else if (select && ctrl.dr_shift) begin
            // tdi enters at the top, LSB leaves toward TDO
            shift_q <= {tdi, shift_q[$bits(shift_q)-1:1]};
        end
    end

    assign tdo_bit = shift_q[0];

endmodule

// ==== design/tap_ir.sv ====
// Instruction register with shift and hold stages plus decoder
// Hold stage falls back to IDCODE whenever the TAP is in reset

`include "tapc_defines.svh"

module tap_ir (
    input  logic                 tck,
    input  logic                 trst_n,
    input  logic                 tdi,
    tapc_ctrl_if.ir              ctrl,
    output logic                 ir_lsb,      // Serial out during Shift-IR
    output tapc_pkg::dr_sel_e    dr_sel,
    output logic                 dmi_ch_sel,
    output tapc_pkg::dmi_id_t    dmi_ch_id
);

    tapc_pkg::instr_t ir_shift_q;  // Shift stage
    tapc_pkg::instr_t ir_hold_q;   // Active instruction

    // ----------------------------------------------------------------------
    // Shift stage
    // ----------------------------------------------------------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            ir_shift_q <= '0;
        end else if (ctrl.tlr) begin
            ir_shift_q <= '0;
        end else if (ctrl.state == tapc_pkg::TAP_IR_CAPTURE) begin
            ir_shift_q <= {{(`TAPC_IR_WIDTH-1){1'b0}}, 1'b1};  // Fixed 00001 pattern
        end else if (ctrl.ir_shift) begin
            ir_shift_q <= {tdi, ir_shift_q[`TAPC_IR_WIDTH-1:1]};  // LSB out first
        end
    end

    assign ir_lsb = ir_shift_q[0];

    // Hold stage, loads mid-cycle in Update-IR
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            ir_hold_q <= `TAPC_INSTR_IDCODE;
        end else if (ctrl.tlr) begin
            ir_hold_q <= `TAPC_INSTR_IDCODE;
        end else if (ctrl.state == tapc_pkg::TAP_IR_UPDATE) begin
            ir_hold_q <= ir_shift_q;
        end
    end

    // ----------------------------------------------------------------------
    // Decoder
    // ----------------------------------------------------------------------
    always_comb begin
        dr_sel     = tapc_pkg::SEL_BYPASS;  // Unknown codes land here
        dmi_ch_sel = 1'b0;
        dmi_ch_id  = '0;
        case (ir_hold_q)
            `TAPC_INSTR_IDCODE: dr_sel = tapc_pkg::SEL_IDCODE;
            `TAPC_INSTR_BLD_ID: dr_sel = tapc_pkg::SEL_BLD_ID;
            `TAPC_INSTR_DTMCS: begin
                dr_sel     = tapc_pkg::SEL_DMI;
                dmi_ch_sel = 1'b1;
                dmi_ch_id  = `TAPC_DMI_ID_DTMCS;
            end
            `TAPC_INSTR_DMI_ACCESS: begin
                dr_sel     = tapc_pkg::SEL_DMI;
                dmi_ch_sel = 1'b1;
                dmi_ch_id  = `TAPC_DMI_ID_ACCESS;
            end
            default: dr_sel = tapc_pkg::SEL_BYPASS;   // BYPASS code included
        endcase
    end

endmodule

// ==== design/tap_fsm.sv ====
// TAP state machine with its logic reset and registered strobes
// Drives every member of the control interface

module tap_fsm (
    input  logic        tck,
    input  logic        trst_n,
    input  logic        tms,
    tapc_ctrl_if.fsm    ctrl
);

    tapc_pkg::tap_state_e state_next;
    logic                 dr_shift_src;   // States that lead into Shift-DR
    logic                 ir_shift_src;   // States that lead into Shift-IR
    logic                 dr_update_src;  // States that lead into Update-DR

    // ----------------------------------------------------------------------
    // State register and next-state table
    // ----------------------------------------------------------------------
    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            ctrl.state <= tapc_pkg::TAP_RESET;
        end else begin
            ctrl.state <= state_next;
        end
    end

    always_comb begin
        case (ctrl.state)
            tapc_pkg::TAP_RESET:
                state_next = tms ? tapc_pkg::TAP_RESET : tapc_pkg::TAP_IDLE;
            tapc_pkg::TAP_IDLE:
                state_next = tms ? tapc_pkg::TAP_DR_SELECT : tapc_pkg::TAP_IDLE;
            tapc_pkg::TAP_DR_SELECT:
                state_next = tms ? tapc_pkg::TAP_IR_SELECT : tapc_pkg::TAP_DR_CAPTURE;
            tapc_pkg::TAP_DR_CAPTURE:
                state_next = tms ? tapc_pkg::TAP_DR_EXIT1 : tapc_pkg::TAP_DR_SHIFT;
            tapc_pkg::TAP_DR_SHIFT:
                state_next = tms ? tapc_pkg::TAP_DR_EXIT1 : tapc_pkg::TAP_DR_SHIFT;
            tapc_pkg::TAP_DR_EXIT1:
                state_next = tms ? tapc_pkg::TAP_DR_UPDATE : tapc_pkg::TAP_DR_PAUSE;
            tapc_pkg::TAP_DR_PAUSE:
                state_next = tms ? tapc_pkg::TAP_DR_EXIT2 : tapc_pkg::TAP_DR_PAUSE;
            tapc_pkg::TAP_DR_EXIT2:
                state_next = tms ? tapc_pkg::TAP_DR_UPDATE : tapc_pkg::TAP_DR_SHIFT;
            tapc_pkg::TAP_DR_UPDATE:
                state_next = tms ? tapc_pkg::TAP_DR_SELECT : tapc_pkg::TAP_IDLE;
            tapc_pkg::TAP_IR_SELECT:
                state_next = tms ? tapc_pkg::TAP_RESET : tapc_pkg::TAP_IR_CAPTURE;
            tapc_pkg::TAP_IR_CAPTURE:
                state_next = tms ? tapc_pkg::TAP_IR_EXIT1 : tapc_pkg::TAP_IR_SHIFT;
            tapc_pkg::TAP_IR_SHIFT:
                state_next = tms ? tapc_pkg::TAP_IR_EXIT1 : tapc_pkg::TAP_IR_SHIFT;
            tapc_pkg::TAP_IR_EXIT1:
                state_next = tms ? tapc_pkg::TAP_IR_UPDATE : tapc_pkg::TAP_IR_PAUSE;
            tapc_pkg::TAP_IR_PAUSE:
                state_next = tms ? tapc_pkg::TAP_IR_EXIT2 : tapc_pkg::TAP_IR_PAUSE;
            tapc_pkg::TAP_IR_EXIT2:
                state_next = tms ? tapc_pkg::TAP_IR_UPDATE : tapc_pkg::TAP_IR_SHIFT;
            tapc_pkg::TAP_IR_UPDATE:
                state_next = tms ? tapc_pkg::TAP_DR_SELECT : tapc_pkg::TAP_IDLE;
            default:
                state_next = tapc_pkg::TAP_RESET;
        endcase
    end

    // ----------------------------------------------------------------------
    // Logic reset, half a cycle behind the state
    // ----------------------------------------------------------------------
    always_ff @(negedge tck or negedge trst_n) begin
        if (!trst_n) begin
            ctrl.tlr <= 1'b1;
        end else begin
            ctrl.tlr <= (ctrl.state == tapc_pkg::TAP_RESET);
        end
    end

    // ----------------------------------------------------------------------
    // Strobes, high for the cycle spent in the target state
    // ----------------------------------------------------------------------
    assign dr_shift_src  = ctrl.state inside {tapc_pkg::TAP_DR_CAPTURE,
                                              tapc_pkg::TAP_DR_SHIFT,
                                              tapc_pkg::TAP_DR_EXIT2};
    assign ir_shift_src  = ctrl.state inside {tapc_pkg::TAP_IR_CAPTURE,
                                              tapc_pkg::TAP_IR_SHIFT,
                                              tapc_pkg::TAP_IR_EXIT2};
    assign dr_update_src = ctrl.state inside {tapc_pkg::TAP_DR_EXIT1,
                                              tapc_pkg::TAP_DR_EXIT2};

    always_ff @(posedge tck or negedge trst_n) begin
        if (!trst_n) begin
            ctrl.dr_capture <= 1'b0;
            ctrl.dr_shift   <= 1'b0;
            ctrl.dr_update  <= 1'b0;
            ctrl.ir_shift   <= 1'b0;
        end else begin
            ctrl.dr_capture <= (ctrl.state == tapc_pkg::TAP_DR_SELECT) & ~tms & ~ctrl.tlr;
            ctrl.dr_shift   <= dr_shift_src  & ~tms & ~ctrl.tlr;
            ctrl.dr_update  <= dr_update_src &  tms & ~ctrl.tlr;
            ctrl.ir_shift   <= ir_shift_src  & ~tms & ~ctrl.tlr;
        end
    end

endmodule

// ==== design/tapc_ctrl_if.sv ====
// State and control strobes from the TAP state machine
// Shared by the instruction register, data registers and TDO stage

interface tapc_ctrl_if;

    tapc_pkg::tap_state_e state;       // Current TAP state
    logic                 tlr;         // Logic reset, active high
    logic                 ir_shift;    // High during Shift-IR
    logic                 dr_capture;  // High during Capture-DR
    logic                 dr_shift;    // High during Shift-DR
    logic                 dr_update;   // High during Update-DR

    // ----------------------------------------------------------------------
    // Views
    // ----------------------------------------------------------------------
    modport fsm (
        output state, tlr, ir_shift, dr_capture, dr_shift, dr_update
    );

    // IR needs the state for Capture-IR and Update-IR
    modport ir  (input state, tlr, ir_shift);

    modport dr  (input tlr, dr_capture, dr_shift);

    // BYPASS bit lives in the TDO stage, hence the capture strobe
    modport tdo (input tlr, ir_shift, dr_capture, dr_shift);

endinterface

// ==== design/tapc_pkg.sv ====
// Types shared by the TAP controller modules
// Referenced by scoped names, widths come from the defines header

`include "tapc_defines.svh"

package tapc_pkg;

    // ----------------------------------------------------------------------
    // TAP state machine, the sixteen IEEE 1149.1 states
    // ----------------------------------------------------------------------
    typedef enum logic [3:0] {
        TAP_RESET      = 4'd0,   // Test-Logic-Reset
        TAP_IDLE       = 4'd1,   // Run-Test/Idle
        TAP_DR_SELECT  = 4'd2,
        TAP_DR_CAPTURE = 4'd3,
        TAP_DR_SHIFT   = 4'd4,
        TAP_DR_EXIT1   = 4'd5,
        TAP_DR_PAUSE   = 4'd6,
        TAP_DR_EXIT2   = 4'd7,
        TAP_DR_UPDATE  = 4'd8,
        TAP_IR_SELECT  = 4'd9,
        TAP_IR_CAPTURE = 4'd10,
        TAP_IR_SHIFT   = 4'd11,
        TAP_IR_EXIT1   = 4'd12,
        TAP_IR_PAUSE   = 4'd13,
        TAP_IR_EXIT2   = 4'd14,
        TAP_IR_UPDATE  = 4'd15
    } tap_state_e;

    // Instruction and data words
    typedef logic [`TAPC_IR_WIDTH-1:0]     instr_t;
    typedef logic [`TAPC_DR_WIDTH-1:0]     dr_word_t;
    typedef logic [`TAPC_DMI_ID_WIDTH-1:0] dmi_id_t;

    // Data register in front of TDO
    // IDCODE and BLD_ID match their generate loop index
    typedef enum logic [1:0] {
        SEL_IDCODE = 2'd0,
        SEL_BLD_ID = 2'd1,
        SEL_BYPASS = 2'd2,
        SEL_DMI    = 2'd3    // External DMI chain
    } dr_sel_e;

endpackage

// ==== design/tapc_defines.svh ====
// Widths, instruction codes and constants of the JTAG TAP controller
// Include in any file that refers to one of the values below

`ifndef TAPC_DEFINES_SVH
`define TAPC_DEFINES_SVH

// ----------------------------------------------------------------------
// Register widths
// ----------------------------------------------------------------------
`define TAPC_IR_WIDTH       5
`define TAPC_DR_WIDTH       32
`define TAPC_DMI_ID_WIDTH   2

// IDCODE and BLD_ID share one register implementation
`define TAPC_NUM_ID_REGS    2

// Build identifier returned by BLD_ID
`define TAPC_BLD_ID_VALUE   32'h2019_0301

// ----------------------------------------------------------------------
// Instruction codes
// ----------------------------------------------------------------------
`define TAPC_INSTR_IDCODE       5'h01
`define TAPC_INSTR_BLD_ID       5'h04
`define TAPC_INSTR_DTMCS        5'h10
`define TAPC_INSTR_DMI_ACCESS   5'h11
`define TAPC_INSTR_BYPASS       5'h1F

// DMI chain identifiers
`define TAPC_DMI_ID_DTMCS       2'd1
`define TAPC_DMI_ID_ACCESS      2'd2

`endif
